// File: jtframe_pkg.sv
// Shared constants for the ROM framework
// Address and data widths of the ROM space and the word memory
// Read latency and refresh slot timing
// Byte lane mask convention and its decode function

package jtframe_pkg;

    localparam int ADDR_W = 22;     // Word address of the whole ROM space
    localparam int MEM_AW = 12;     // Low address bits the memory keeps
    localparam int DW     = 16;     // Memory word width
    localparam int MASK_W = DW / 8; // One mask bit per byte lane

    // Cycles from a granted read to its returned word
    localparam int RD_LAT = 2;

    // Refresh slots, only while refresh_en is high
    localparam int REFRESH_PERIOD = 64;
    localparam int REFRESH_CYCLES = 4;  // Memory busy time per slot
    localparam int REF_TW = $clog2(REFRESH_PERIOD + 1);
    localparam int REF_CW = $clog2(REFRESH_CYCLES + 1);

    // Mask bits work like DQM on the chip.
    // A zero enables its lane, bit 0 covers wdata[7:0] and bit 1 covers wdata[15:8]
    localparam logic [MASK_W-1:0] MASK_NONE = '1;  // Touch no lane

    // Lanes that a write with this mask updates
    function automatic logic [MASK_W-1:0] lane_en(input logic [MASK_W-1:0] mask);
        return ~mask;
    endfunction

endpackage

// File: jtframe_mem_if.sv
// Memory request channel between clients, arbiter and memory
// Request fields, one-cycle grant and the read return
// Modports for the client, the arbiter and the memory sides

interface jtframe_mem_if import jtframe_pkg::*; ();

    logic              req;     // Held by the client until gnt
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DW-1:0]     wdata;
    logic [MASK_W-1:0] wmask;   // Active low lane enables
    logic              gnt;     // Command enters memory this cycle
    logic              rvalid;  // RD_LAT cycles after a read grant
    logic [DW-1:0]     rdata;

    modport client (
        output req, we, addr, wdata, wmask,
        input  gnt, rvalid, rdata
    );

    modport arb (
        input  req, we, addr, wdata, wmask,
        output gnt, rvalid, rdata
    );

    modport mem (
        input  req, we, addr, wdata, wmask,
        output gnt, rvalid, rdata
    );

endinterface

// File: jtframe_prog.sv
// ROM download client
// Latches one byte write on prog_we and holds it on the bus
// until the arbiter grants it

module jtframe_prog import jtframe_pkg::*; (
    input  logic              clk_rom,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    input  logic [MASK_W-1:0] prog_mask,
    input  logic              prog_we,
    jtframe_mem_if.client     bus
);

    logic              pending;     // Write waiting for its grant
    logic [ADDR_W-1:0] wr_addr;
    logic [DW-1:0]     wr_data;
    logic [MASK_W-1:0] wr_mask;

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            if (prog_we) begin
                pending <= 1'b1;
            end else if (bus.gnt) begin
                pending <= 1'b0;
            end
        end
    end

    // Payload of the pending write
    always_ff @(posedge clk_rom) begin
        if (prog_we) begin
            wr_addr <= prog_addr;
            wr_data <= {MASK_W{prog_data}};  // Same byte on both lanes
            wr_mask <= prog_mask;            // Mask picks the lane
        end
    end

    assign bus.req   = pending;
    assign bus.we    = pending;
    assign bus.addr  = wr_addr;
    assign bus.wdata = wr_data;
    assign bus.wmask = wr_mask;

    // The loader must leave room for the previous write to drain
    a_no_overrun: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        prog_we |-> !pending
    ) else $error("prog_we while a write is still pending");

endmodule

// File: jtframe_rom_read.sv
// Game ROM read port
// Takes one sdram_req, issues two word reads at addr and addr+1
// and assembles the 32-bit data_read from the two returns
// FSM plus a return counter

module jtframe_rom_read import jtframe_pkg::*; (
    input  logic              clk_rom,
    input  logic              rst_n,
    input  logic              sdram_req,
    input  logic [ADDR_W-1:0] sdram_addr,
    output logic              sdram_ack,
    output logic [31:0]       data_read,
    output logic              data_rdy,
    jtframe_mem_if.client     bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LO,      // Requesting word addr
        ST_HI,      // Requesting word addr+1
        ST_WAIT     // Both issued, waiting for returns
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] base;
    logic              rcnt;        // Set once the low word is back
    logic [DW-1:0]     lo_word;
    logic              ack_open;    // Ack given, data_rdy not yet

    assign bus.req   = (state == ST_LO) || (state == ST_HI);
    assign bus.we    = 1'b0;
    assign bus.addr  = (state == ST_HI) ? base + 1'b1 : base;
    assign bus.wdata = '0;
    assign bus.wmask = MASK_NONE;

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            rcnt      <= 1'b0;
            ack_open  <= 1'b0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (sdram_req) begin
                        state     <= ST_LO;
                        sdram_ack <= 1'b1;
                        rcnt      <= 1'b0;
                    end
                end
                ST_LO:   if (bus.gnt) state <= ST_HI;
                ST_HI:   if (bus.gnt) state <= ST_WAIT;
                default: ;  // ST_WAIT leaves on the second return
            endcase
            if (bus.rvalid) begin
                rcnt <= ~rcnt;
                if (rcnt) begin
                    data_rdy <= 1'b1;
                    state    <= ST_IDLE;
                end
            end
            if (sdram_ack) begin
                ack_open <= 1'b1;
            end else if (data_rdy) begin
                ack_open <= 1'b0;
            end
        end
    end

    // Address and returned data
    always_ff @(posedge clk_rom) begin
        if (state == ST_IDLE && sdram_req) base <= sdram_addr;
        if (bus.rvalid) begin
            if (!rcnt) begin
                lo_word <= bus.rdata;
            end else begin
                data_read <= {bus.rdata, lo_word};  // addr+1 on top
            end
        end
    end

    a_rdy_after_ack: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        data_rdy |-> ack_open
    ) else $error("data_rdy without a matching sdram_ack");

    // Returns only come back for reads this port has issued
    a_return_expected: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        bus.rvalid |-> (state == ST_HI || state == ST_WAIT)
    ) else $error("unexpected read return on the game port");

endmodule

// File: jtframe_mem_arb.sv
// Memory arbiter for the download and game read clients
// Refresh timer and slot counter, fixed priority grant
// Command mux toward the memory
// Tag pipeline that routes each read return to its client

module jtframe_mem_arb import jtframe_pkg::*; (
    input  logic          clk_rom,
    input  logic          rst_n,
    input  logic          refresh_en,
    jtframe_mem_if.arb    prog,
    jtframe_mem_if.arb    rd,
    jtframe_mem_if.client ram
);

    logic [REF_TW-1:0] ref_timer;
    logic [REF_CW-1:0] ref_slot;    // Cycles left in the refresh slot
    logic              ref_busy;
    logic              ref_due;
    logic              prog_gnt;
    logic              rd_gnt;
    logic [RD_LAT-1:0] tag_rd;      // Command at this stage came from the game port

    assign ref_busy = ref_slot != '0;
    assign ref_due  = refresh_en && (ref_timer == REF_TW'(REFRESH_PERIOD));

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            ref_timer <= '0;
            ref_slot  <= '0;
        end else begin
            if (ref_due) begin
                ref_timer <= '0;
                ref_slot  <= REF_CW'(REFRESH_CYCLES);  // Slot starts next cycle
            end else begin
                if (refresh_en) ref_timer <= ref_timer + 1'b1;
                if (ref_busy)   ref_slot  <= ref_slot - 1'b1;
            end
        end
    end

    // Refresh first, then download, then game reads
    assign prog_gnt = !ref_busy && prog.req;
    assign rd_gnt   = !ref_busy && !prog.req && rd.req;
    assign prog.gnt = prog_gnt;
    assign rd.gnt   = rd_gnt;

    always_comb begin
        ram.req = prog_gnt || rd_gnt;
        if (prog_gnt) begin
            ram.we    = prog.we;
            ram.addr  = prog.addr;
            ram.wdata = prog.wdata;
            ram.wmask = prog.wmask;
        end else begin
            ram.we    = rd.we;
            ram.addr  = rd.addr;
            ram.wdata = rd.wdata;
            ram.wmask = rd.wmask;
        end
    end

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            tag_rd <= '0;
        end else begin
            tag_rd[0] <= rd_gnt;
            for (int i = 1; i < RD_LAT; i++) begin
                tag_rd[i] <= tag_rd[i-1];
            end
        end
    end

    assign prog.rvalid = ram.rvalid && !tag_rd[RD_LAT-1];
    assign rd.rvalid   = ram.rvalid &&  tag_rd[RD_LAT-1];
    assign prog.rdata  = ram.rdata;
    assign rd.rdata    = ram.rdata;

    a_gnt_onehot: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        $onehot0({prog_gnt, rd_gnt})
    ) else $error("more than one client granted");

    a_refresh_idle: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        ref_busy |-> !prog.gnt && !rd.gnt
    ) else $error("grant during a refresh slot");

endmodule

// File: jtframe_ram.sv
// Behavioral word memory standing in for the SDRAM chip
// Byte lane writes under an active low mask
// Reads through an RD_LAT stage pipeline

module jtframe_ram import jtframe_pkg::*; (
    input  logic       clk_rom,
    input  logic       rst_n,
    jtframe_mem_if.mem bus
);

    logic [DW-1:0]     mem [2**MEM_AW];
    logic [MEM_AW-1:0] word;            // Upper address bits are ignored
    logic [MASK_W-1:0] lanes;
    logic [RD_LAT-1:0] rd_v;
    logic [DW-1:0]     rd_pipe [RD_LAT];

    assign word    = bus.addr[MEM_AW-1:0];
    assign lanes   = lane_en(bus.wmask);
    assign bus.gnt = bus.req;           // Every command is taken

    always_ff @(posedge clk_rom) begin
        if (bus.req && bus.we) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (lanes[i]) mem[word][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
        if (bus.req && !bus.we) rd_pipe[0] <= mem[word];
        for (int i = 1; i < RD_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // Valid bits follow the data through the pipe
    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            rd_v <= '0;
        end else begin
            rd_v[0] <= bus.req && !bus.we;
            for (int i = 1; i < RD_LAT; i++) begin
                rd_v[i] <= rd_v[i-1];
            end
        end
    end

    assign bus.rvalid = rd_v[RD_LAT-1];
    assign bus.rdata  = rd_pipe[RD_LAT-1];

endmodule

// File: jtframe_rom_sys.sv
// ROM subsystem top level
// Download client, game read port, arbiter with refresh
// and the word memory, joined by three request channels

module jtframe_rom_sys import jtframe_pkg::*; (
    input  logic              clk_rom,
    input  logic              rst_n,
    input  logic              refresh_en,
    // ROM download
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    input  logic [MASK_W-1:0] prog_mask,
    input  logic              prog_we,
    // Game ROM reads
    input  logic              sdram_req,
    input  logic [ADDR_W-1:0] sdram_addr,
    output logic              sdram_ack,
    output logic [31:0]       data_read,
    output logic              data_rdy
);

    jtframe_mem_if prog_bus();
    jtframe_mem_if read_bus();
    jtframe_mem_if ram_bus();

    jtframe_prog u_prog (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .bus        ( prog_bus   )
    );

    jtframe_rom_read u_read (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_read  ( data_read  ),
        .data_rdy   ( data_rdy   ),
        .bus        ( read_bus   )
    );

    jtframe_mem_arb u_arb (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .refresh_en ( refresh_en ),
        .prog       ( prog_bus   ),
        .rd         ( read_bus   ),
        .ram        ( ram_bus    )
    );

    jtframe_ram u_ram (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .bus        ( ram_bus    )
    );

endmodule

// File: jtframe_rom_tb.sv
// Testbench for the ROM subsystem
// Clock, reset, download and game read tasks, LCG stimulus
// Shadow memory model under the active low byte mask
// Concurrent checks on the game read port

module jtframe_rom_tb import jtframe_pkg::*; ();

    localparam int WAIT_LIMIT = 200;    // Cycles allowed for each wait
    localparam int RANGE_N    = 16;     // Words in the download range
    localparam logic [MEM_AW-1:0] LAST_WORD = '1;

    logic              clk_rom;
    logic              rst_n;
    logic              refresh_en;
    logic [ADDR_W-1:0] prog_addr;
    logic [7:0]        prog_data;
    logic [1:0]        prog_mask;
    logic              prog_we;
    logic              sdram_req;
    logic [ADDR_W-1:0] sdram_addr;
    logic              sdram_ack;
    logic [31:0]       data_read;
    logic              data_rdy;

    logic [15:0]       shadow [2**MEM_AW];  // Expected memory contents
    logic [31:0]       seed;
    logic [ADDR_W-1:0] req_addr;            // Address of the read in progress
    logic [31:0]       exp_data;
    logic              req_seen;
    logic              open_rd;             // Between sdram_ack and data_rdy
    logic              hung;
    int                errors;
    int                reads_done;
    logic [MEM_AW-1:0] range_low;

    jtframe_rom_sys dut (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .refresh_en ( refresh_en ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_read  ( data_read  ),
        .data_rdy   ( data_rdy   )
    );

    initial begin
        clk_rom = 1'b0;
        forever #50 clk_rom = ~clk_rom;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Random upper bits that the memory ignores
    function automatic logic [ADDR_W-1:0] rom_addr(input logic [MEM_AW-1:0] low);
        logic [31:0] r;
        r = next_rand();
        return {r[ADDR_W-MEM_AW-1:0], low};
    endfunction

    // Expected words are captured when the read is acknowledged
    always @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            open_rd  <= 1'b0;
            exp_data <= '0;
        end else if (sdram_ack) begin
            open_rd  <= 1'b1;
            exp_data <= {shadow[MEM_AW'(req_addr + 1)], shadow[req_addr[MEM_AW-1:0]]};
        end else if (data_rdy) begin
            open_rd <= 1'b0;
        end
    end

    a_quiet: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        !req_seen |-> !sdram_ack && !data_rdy
    ) else begin
        errors++;
        $display("sdram_ack or data_rdy went high before any request");
    end

    a_single_ack: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        sdram_ack |-> !open_rd
    ) else begin
        errors++;
        $display("sdram_ack came again before the previous data_rdy");
    end

    a_rdy_open: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        data_rdy |-> open_rd
    ) else begin
        errors++;
        $display("data_rdy arrived without an open sdram_ack");
    end

    a_data: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        data_rdy |-> data_read == exp_data
    ) else begin
        errors++;
        $display("ERROR data_read 0x%08h expected 0x%08h", data_read, exp_data);
    end

    task automatic note_hang(input string what);
        $display("Timeout: %s", what);
        errors++;
        hung = 1'b1;
    endtask

    // One download strobe every 8 cycles
    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [7:0] d,
                              input logic [1:0] m);
        logic [15:0] w;
        if (hung) return;
        w = shadow[a[MEM_AW-1:0]];
        if (!m[0]) w[7:0] = d;      // Zero enables the lane
        if (!m[1]) w[15:8] = d;
        @(posedge clk_rom);
        prog_addr <= a;
        prog_data <= d;
        prog_mask <= m;
        prog_we   <= 1'b1;
        shadow[a[MEM_AW-1:0]] <= w;
        @(posedge clk_rom);
        prog_we <= 1'b0;
        repeat (6) @(posedge clk_rom);
    endtask

    task automatic read_pair(input logic [ADDR_W-1:0] a);
        int   n;
        logic got;
        if (hung) return;
        @(posedge clk_rom);
        sdram_req  <= 1'b1;
        sdram_addr <= a;
        req_addr   <= a;
        req_seen   <= 1'b1;
        got = 1'b0;
        n = 0;
        while (!got && n < WAIT_LIMIT) begin
            @(posedge clk_rom);
            got = sdram_ack;
            n++;
        end
        sdram_req <= 1'b0;      // Dropped once acknowledged
        if (!got) begin
            note_hang($sformatf("no sdram_ack for address %06h", a));
            return;
        end
        got = 1'b0;
        n = 0;
        while (!got && n < WAIT_LIMIT) begin
            @(posedge clk_rom);
            got = data_rdy;
            n++;
        end
        if (!got) begin
            note_hang($sformatf("no data_rdy for address %06h", a));
            return;
        end
        reads_done++;
    endtask

    task automatic test_done(input int num, input string name);
        $display("test %0d %s finished, errors so far %0d", num, name, errors);
    endtask

    initial begin
        seed       = 32'd84881;
        errors     = 0;
        reads_done = 0;
        hung       = 1'b0;
        req_seen   = 1'b0;
        req_addr   = '0;
        rst_n      = 1'b0;
        refresh_en = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        prog_mask  = 2'b11;
        prog_we    = 1'b0;
        sdram_req  = 1'b0;
        sdram_addr = '0;
        repeat (3) @(posedge clk_rom);
        rst_n <= 1'b1;

        repeat (20) @(posedge clk_rom);     // Idle port stays quiet
        test_done(1, "idle after reset");

        range_low = MEM_AW'(next_rand());
        for (int i = 0; i < RANGE_N; i++) begin
            write_byte(rom_addr(range_low + MEM_AW'(i)), 8'(next_rand()), 2'b00);
        end
        for (int i = 0; i < RANGE_N - 1; i++) begin
            read_pair(rom_addr(range_low + MEM_AW'(i)));
        end
        test_done(2, "download and readback");

        write_byte(rom_addr(range_low + MEM_AW'(3)), 8'(next_rand()), 2'b00);
        read_pair(rom_addr(range_low + MEM_AW'(3)));
        write_byte(rom_addr(range_low + MEM_AW'(3)), 8'(next_rand()), 2'b10);   // Low lane only
        read_pair(rom_addr(range_low + MEM_AW'(3)));
        write_byte(rom_addr(range_low + MEM_AW'(3)), 8'(next_rand()), 2'b01);   // High lane only
        read_pair(rom_addr(range_low + MEM_AW'(3)));
        read_pair(rom_addr(range_low + MEM_AW'(2)));
        test_done(3, "byte lane masks");

        // Downloads go to a disjoint region while the game reads
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    write_byte(rom_addr(range_low + 12'h800 + MEM_AW'(i)),
                               8'(next_rand()), 2'b00);
                end
            end
            begin
                for (int i = 0; i < 10; i++) begin
                    read_pair(rom_addr(range_low + MEM_AW'(i)));
                end
            end
        join
        test_done(4, "reads during download");

        @(posedge clk_rom);
        refresh_en <= 1'b1;
        for (int i = 0; i < 60; i++) begin
            read_pair(rom_addr(range_low + MEM_AW'(next_rand() % (RANGE_N - 1))));
        end
        test_done(5, "random reads with refresh");

        write_byte(rom_addr(LAST_WORD), 8'(next_rand()), 2'b10);
        write_byte(rom_addr(LAST_WORD), 8'(next_rand()), 2'b01);
        write_byte(rom_addr('0), 8'(next_rand()), 2'b10);
        write_byte(rom_addr('0), 8'(next_rand()), 2'b01);
        read_pair(rom_addr(LAST_WORD));     // Second word wraps to 0
        test_done(6, "wrap at last word");

        repeat (4) @(posedge clk_rom);
        $display("tests 6, reads %0d, errors %0d", reads_done, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
jtframe_pkg.sv
jtframe_mem_if.sv
jtframe_prog.sv
jtframe_rom_read.sv
jtframe_mem_arb.sv
jtframe_ram.sv
jtframe_rom_sys.sv
jtframe_rom_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROM subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module jtframe_rom_tb -o jtframe_rom_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/jtframe_rom_tb > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
